// File: all.f
rtl/id_pkg.sv
rtl/id_inst_latch.sv
rtl/id_regfile.sv
rtl/id_operand_bypass.sv
rtl/id_ctrl_decode.sv
rtl/id_branch_unit.sv
rtl/id_stage.sv
tb/id_stage_sva.sv
tb/id_stage_tb.sv

// File: rtl/id_branch_unit.sv
`timescale 1ns/100ps

module id_branch_unit (
    input  id_pkg::word_t   pc,
    input  id_pkg::word_t   inst,
    input  id_pkg::word_t   rs_val,
    input  id_pkg::word_t   rt_val,
    output id_pkg::branch_t branch
);

    logic [id_pkg::op_w-1:0] opcode;
    logic [id_pkg::op_w-1:0] funct;
    id_pkg::word_t           pc_plus_4;
    id_pkg::word_t           br_target;
    id_pkg::word_t           jmp_target;

    assign opcode    = inst[id_pkg::op_lsb +: id_pkg::op_w];
    assign funct     = inst[id_pkg::op_w-1:0];
    assign pc_plus_4 = pc + 32'd4;

    // pc-relative, word offset
    assign br_target = pc_plus_4 + {{(id_pkg::word_w-id_pkg::imm_w-2){inst[id_pkg::imm_w-1]}},
                                    inst[id_pkg::imm_w-1:0], 2'b00};

    // stays inside the current 256 MB region
    assign jmp_target = {pc_plus_4[id_pkg::word_w-1 -: 4], inst[id_pkg::index_w-1:0], 2'b00};

    always_comb begin
        branch = '0;
        case (opcode)
            id_pkg::op_beq: begin
                branch.taken  = (rs_val == rt_val);
                branch.target = br_target;
            end
            id_pkg::op_bne: begin
                branch.taken  = (rs_val != rt_val);
                branch.target = br_target;
            end
            id_pkg::op_j, id_pkg::op_jal: begin
                branch.taken  = 1'b1;
                branch.target = jmp_target;
            end
            id_pkg::op_special: begin
                if (funct == id_pkg::fn_jr) begin
                    branch.taken  = 1'b1;
                    branch.target = rs_val;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/id_ctrl_decode.sv
`timescale 1ns/100ps

module id_ctrl_decode (
    input  id_pkg::word_t inst,
    output id_pkg::ctrl_t ctrl
);

    logic [id_pkg::op_w-1:0] opcode;
    logic [id_pkg::op_w-1:0] funct;
    id_pkg::reg_addr_t       rt;
    id_pkg::reg_addr_t       rd;

    assign opcode = inst[id_pkg::op_lsb +: id_pkg::op_w];
    assign funct  = inst[id_pkg::op_w-1:0];
    assign rt     = inst[id_pkg::rt_lsb +: id_pkg::reg_aw];
    assign rd     = inst[id_pkg::rd_lsb +: id_pkg::reg_aw];

    always_comb begin
        ctrl = '0;
        case (opcode)
            // ********************
            // r-type alu
            // ********************
            id_pkg::op_special: begin
                case (funct)
                    id_pkg::fn_addu: ctrl.alu_op[id_pkg::alu_add]  = 1'b1;
                    id_pkg::fn_subu: ctrl.alu_op[id_pkg::alu_sub]  = 1'b1;
                    id_pkg::fn_and:  ctrl.alu_op[id_pkg::alu_and]  = 1'b1;
                    id_pkg::fn_or:   ctrl.alu_op[id_pkg::alu_or]   = 1'b1;
                    id_pkg::fn_xor:  ctrl.alu_op[id_pkg::alu_xor]  = 1'b1;
                    id_pkg::fn_nor:  ctrl.alu_op[id_pkg::alu_nor]  = 1'b1;
                    id_pkg::fn_slt:  ctrl.alu_op[id_pkg::alu_slt]  = 1'b1;
                    id_pkg::fn_sltu: ctrl.alu_op[id_pkg::alu_sltu] = 1'b1;
                    default: ;
                endcase
                // jr and unknown functs leave alu_op clear and write nothing
                if (ctrl.alu_op != '0) begin
                    ctrl.src1_sel = id_pkg::src1_rs;
                    ctrl.src2_sel = id_pkg::src2_rt;
                    ctrl.rf_we    = 1'b1;
                    ctrl.rf_waddr = rd;
                end
            end
            // ********************
            // immediate alu
            // ********************
            id_pkg::op_addiu: begin
                ctrl.alu_op[id_pkg::alu_add] = 1'b1;
                ctrl.src2_sel = id_pkg::src2_imm_sext;
            end
            id_pkg::op_andi: begin
                ctrl.alu_op[id_pkg::alu_and] = 1'b1;
                ctrl.src2_sel = id_pkg::src2_imm_zext;
            end
            id_pkg::op_ori: begin
                ctrl.alu_op[id_pkg::alu_or] = 1'b1;
                ctrl.src2_sel = id_pkg::src2_imm_zext;
            end
            id_pkg::op_xori: begin
                ctrl.alu_op[id_pkg::alu_xor] = 1'b1;
                ctrl.src2_sel = id_pkg::src2_imm_zext;
            end
            id_pkg::op_lui: begin
                ctrl.alu_op[id_pkg::alu_lui] = 1'b1;
                ctrl.src2_sel = id_pkg::src2_imm_sext;
            end
            // memory, address is rs + sext(imm)
            id_pkg::op_lw: begin
                ctrl.alu_op[id_pkg::alu_add] = 1'b1;
                ctrl.src2_sel   = id_pkg::src2_imm_sext;
                ctrl.mem_en     = 1'b1;
                ctrl.sel_rf_res = 1'b1;
            end
            id_pkg::op_sw: begin
                ctrl.alu_op[id_pkg::alu_add] = 1'b1;
                ctrl.src2_sel = id_pkg::src2_imm_sext;
                ctrl.mem_en   = 1'b1;
                ctrl.mem_we   = 1'b1;
            end
            // link value is pc + 8
            id_pkg::op_jal: begin
                ctrl.alu_op[id_pkg::alu_add] = 1'b1;
                ctrl.src1_sel = id_pkg::src1_pc;
                ctrl.src2_sel = id_pkg::src2_const8;
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = id_pkg::reg_link;
            end
            default: ;
        endcase
        // i-type results go to rt
        if (opcode inside {id_pkg::op_addiu, id_pkg::op_andi, id_pkg::op_ori,
                           id_pkg::op_xori, id_pkg::op_lui, id_pkg::op_lw}) begin
            ctrl.rf_we    = 1'b1;
            ctrl.rf_waddr = rt;
        end
    end

endmodule

// File: rtl/id_inst_latch.sv
`timescale 1ns/100ps

module id_inst_latch (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall_if,
    input  logic              stall_id,
    input  id_pkg::if_to_id_t if_to_id,
    input  id_pkg::word_t     inst_rdata,
    output id_pkg::word_t     pc,
    output id_pkg::word_t     inst
);

    id_pkg::if_to_id_t if_id_r;
    id_pkg::word_t     slot;
    logic              slot_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id_r    <= '0;
            slot_valid <= 1'b0;
        end else if (!stall_if) begin
            if_id_r    <= if_to_id;
            slot_valid <= 1'b0;
        end else if (!stall_id) begin
            // fetch held, decode moves on: bubble
            if_id_r    <= '0;
            slot_valid <= 1'b0;
        end else if (!slot_valid) begin
            slot_valid <= 1'b1;
        end
    end

    // capture sram data once when both stages stall
    always_ff @(posedge clk) begin
        if (stall_if && stall_id && !slot_valid) begin
            slot <= inst_rdata;
        end
    end

    assign pc = if_id_r.pc;

    // invalid entry decodes as all-zero, a true no-op
    assign inst = !if_id_r.valid ? '0 :
                  slot_valid     ? slot : inst_rdata;

endmodule

// File: rtl/id_operand_bypass.sv
`timescale 1ns/100ps

module id_operand_bypass (
    input  id_pkg::reg_addr_t src_addr,
    input  id_pkg::word_t     rf_data,
    input  id_pkg::rf_write_t ex_fwd,
    input  id_pkg::rf_write_t mem_fwd,
    input  id_pkg::rf_write_t wb_fwd,
    input  logic              ex_is_load,
    output id_pkg::word_t     operand,
    output logic              load_hazard
);

    logic hit_ex;
    logic hit_mem;
    logic hit_wb;

    assign hit_ex  = ex_fwd.we  && (ex_fwd.waddr  == src_addr);
    assign hit_mem = mem_fwd.we && (mem_fwd.waddr == src_addr);
    assign hit_wb  = wb_fwd.we  && (wb_fwd.waddr  == src_addr);

    // newest producer wins
    assign operand = hit_ex  ? ex_fwd.wdata  :
                     hit_mem ? mem_fwd.wdata :
                     hit_wb  ? wb_fwd.wdata  : rf_data;

    // load data in ex is not ready yet, so the ex bypass value is wrong
    assign load_hazard = ex_is_load && hit_ex;

endmodule

// File: rtl/id_pkg.sv
package id_pkg;

    // ********************
    // widths
    // ********************
    localparam int word_w    = 32;
    localparam int reg_aw    = 5;
    localparam int reg_count = 32;
    localparam int op_w      = 6;
    localparam int imm_w     = 16;
    localparam int index_w   = 26;
    localparam int alu_w     = 9;

    // instruction field positions (lsb of each field)
    localparam int op_lsb = 26;
    localparam int rs_lsb = 21;
    localparam int rt_lsb = 16;
    localparam int rd_lsb = 11;

    typedef logic [word_w-1:0] word_t;
    typedef logic [reg_aw-1:0] reg_addr_t;
    typedef logic [alu_w-1:0]  alu_op_t;
    typedef logic [1:0]        src1_sel_t;
    typedef logic [1:0]        src2_sel_t;

    // one-hot alu operation bit positions
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_or   = 5;
    localparam int alu_xor  = 6;
    localparam int alu_nor  = 7;
    localparam int alu_lui  = 8;

    // operand selector codes
    localparam src1_sel_t src1_rs       = 2'd0;
    localparam src1_sel_t src1_pc       = 2'd1;
    localparam src2_sel_t src2_rt       = 2'd0;
    localparam src2_sel_t src2_imm_sext = 2'd1;
    localparam src2_sel_t src2_imm_zext = 2'd2;
    localparam src2_sel_t src2_const8   = 2'd3;

    // ********************
    // opcodes and function codes
    // ********************
    localparam logic [op_w-1:0] op_special = 6'h00;
    localparam logic [op_w-1:0] op_j       = 6'h02;
    localparam logic [op_w-1:0] op_jal     = 6'h03;
    localparam logic [op_w-1:0] op_beq     = 6'h04;
    localparam logic [op_w-1:0] op_bne     = 6'h05;
    localparam logic [op_w-1:0] op_addiu   = 6'h09;
    localparam logic [op_w-1:0] op_andi    = 6'h0c;
    localparam logic [op_w-1:0] op_ori     = 6'h0d;
    localparam logic [op_w-1:0] op_xori    = 6'h0e;
    localparam logic [op_w-1:0] op_lui     = 6'h0f;
    localparam logic [op_w-1:0] op_lw      = 6'h23;
    localparam logic [op_w-1:0] op_sw      = 6'h2b;

    localparam logic [op_w-1:0] fn_jr   = 6'h08;
    localparam logic [op_w-1:0] fn_addu = 6'h21;
    localparam logic [op_w-1:0] fn_subu = 6'h23;
    localparam logic [op_w-1:0] fn_and  = 6'h24;
    localparam logic [op_w-1:0] fn_or   = 6'h25;
    localparam logic [op_w-1:0] fn_xor  = 6'h26;
    localparam logic [op_w-1:0] fn_nor  = 6'h27;
    localparam logic [op_w-1:0] fn_slt  = 6'h2a;
    localparam logic [op_w-1:0] fn_sltu = 6'h2b;

    // link register for jal
    localparam reg_addr_t reg_link = 5'd31;

    // ********************
    // buses
    // ********************
    typedef struct packed {
        logic  valid;
        word_t pc;
    } if_to_id_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_write_t;

    typedef struct packed {
        alu_op_t   alu_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        logic      mem_en;
        logic      mem_we;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      sel_rf_res;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
        ctrl_t ctrl;
        word_t rs_val;
        word_t rt_val;
    } id_to_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

endpackage

// File: rtl/id_regfile.sv
`timescale 1ns/100ps

module id_regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr [2],
    output id_pkg::word_t     rdata [2],
    input  id_pkg::rf_write_t wr
);

    id_pkg::word_t regs [id_pkg::reg_count];

    // writeback port
    always_ff @(posedge clk) begin
        if (wr.we && (wr.waddr != '0)) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // two asynchronous read ports, $zero forced
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (raddr[i] == '0) begin
                rdata[i] = '0;
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

endmodule

// File: rtl/id_stage.sv
`timescale 1ns/100ps

module id_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall_if,
    input  logic              stall_id,
    input  id_pkg::if_to_id_t if_to_id,
    input  id_pkg::word_t     inst_rdata,
    input  id_pkg::rf_write_t ex_fwd,
    input  id_pkg::rf_write_t mem_fwd,
    input  id_pkg::rf_write_t wb_fwd,
    input  logic              ex_is_load,
    output id_pkg::id_to_ex_t id_to_ex,
    output id_pkg::branch_t   branch,
    output logic              stall_for_load
);

    id_pkg::word_t     id_pc;
    id_pkg::word_t     id_inst;
    id_pkg::reg_addr_t src_addr [2];
    id_pkg::word_t     rf_rdata [2];
    id_pkg::word_t     operand [2];
    logic              load_hazard [2];
    id_pkg::ctrl_t     ctrl;

    id_inst_latch u_inst_latch (
        .clk        (clk),
        .rst        (rst),
        .stall_if   (stall_if),
        .stall_id   (stall_id),
        .if_to_id   (if_to_id),
        .inst_rdata (inst_rdata),
        .pc         (id_pc),
        .inst       (id_inst)
    );

    // index 0 is rs, 1 is rt
    assign src_addr[0] = id_inst[id_pkg::rs_lsb +: id_pkg::reg_aw];
    assign src_addr[1] = id_inst[id_pkg::rt_lsb +: id_pkg::reg_aw];

    id_regfile u_regfile (
        .clk   (clk),
        .raddr (src_addr),
        .rdata (rf_rdata),
        .wr    (wb_fwd)
    );

    for (genvar g = 0; g < 2; g++) begin : g_bypass
        id_operand_bypass u_bypass (
            .src_addr    (src_addr[g]),
            .rf_data     (rf_rdata[g]),
            .ex_fwd      (ex_fwd),
            .mem_fwd     (mem_fwd),
            .wb_fwd      (wb_fwd),
            .ex_is_load  (ex_is_load),
            .operand     (operand[g]),
            .load_hazard (load_hazard[g])
        );
    end

    id_ctrl_decode u_ctrl_decode (
        .inst (id_inst),
        .ctrl (ctrl)
    );

    id_branch_unit u_branch_unit (
        .pc     (id_pc),
        .inst   (id_inst),
        .rs_val (operand[0]),
        .rt_val (operand[1]),
        .branch (branch)
    );

    assign stall_for_load = load_hazard[0] | load_hazard[1];

    assign id_to_ex = '{pc: id_pc, inst: id_inst, ctrl: ctrl,
                        rs_val: operand[0], rt_val: operand[1]};

endmodule

// File: tb/id_stage_sva.sv
`timescale 1ns/100ps

module id_stage_sva (
    input logic              clk,
    input logic              rst,
    input logic              ex_is_load,
    input id_pkg::rf_write_t ex_fwd,
    input logic              stall_for_load,
    input id_pkg::id_to_ex_t id_to_ex,
    input id_pkg::branch_t   branch
);

    // load-use stall exactly when the load in ex targets rs or rt
    a_stall_on_load_use: assert property (
        @(posedge clk) disable iff (rst)
        stall_for_load == (ex_is_load && ex_fwd.we &&
            (ex_fwd.waddr == id_to_ex.inst[id_pkg::rs_lsb +: id_pkg::reg_aw] ||
             ex_fwd.waddr == id_to_ex.inst[id_pkg::rt_lsb +: id_pkg::reg_aw]))
    ) else $error("stall_for_load does not follow the load in ex");

    a_we_needs_en: assert property (
        @(posedge clk) disable iff (rst) id_to_ex.ctrl.mem_we |-> id_to_ex.ctrl.mem_en
    ) else $error("memory write without memory enable");

    // latch is invalid after any reset edge, including the first edge out of reset
    a_quiet_after_reset: assert property (
        @(posedge clk) rst |=> (!id_to_ex.ctrl.rf_we && !branch.taken)
    ) else $error("register write or branch taken during reset");

endmodule

bind id_stage id_stage_sva sva_i (
    .clk            (clk),
    .rst            (rst),
    .ex_is_load     (ex_is_load),
    .ex_fwd         (ex_fwd),
    .stall_for_load (stall_for_load),
    .id_to_ex       (id_to_ex),
    .branch         (branch)
);

// File: tb/id_stage_tb.sv
`timescale 1ns/100ps

module id_stage_tb;

    typedef struct {
        id_pkg::word_t     pc;
        id_pkg::word_t     inst;
        id_pkg::rf_write_t ex;
        id_pkg::rf_write_t mem;
        id_pkg::rf_write_t wb;
        logic              ld;
        logic [1:0]        stl;
        id_pkg::word_t     exp_pc;
        id_pkg::word_t     exp_inst;
        id_pkg::word_t     exp_rs;
        id_pkg::word_t     exp_rt;
        id_pkg::ctrl_t     exp_ctrl;
        id_pkg::branch_t   exp_br;
        logic              exp_stall;
    } row_t;

    logic              clk;
    logic              rst;
    logic              stall_if;
    logic              stall_id;
    id_pkg::if_to_id_t if_to_id;
    id_pkg::word_t     inst_rdata;
    id_pkg::rf_write_t ex_fwd;
    id_pkg::rf_write_t mem_fwd;
    id_pkg::rf_write_t wb_fwd;
    logic              ex_is_load;
    id_pkg::id_to_ex_t id_to_ex;
    id_pkg::branch_t   branch;
    logic              stall_for_load;

    // table building state
    row_t              rows [$];
    id_pkg::word_t     model [32];
    id_pkg::word_t     preload_val [1:8];
    id_pkg::rf_write_t ex_s;
    id_pkg::rf_write_t mem_s;
    id_pkg::rf_write_t wb_s;
    logic              ld_s;
    logic [1:0]        stl_s;
    id_pkg::word_t     next_pc;
    int                seed;
    int                cycle_count = 0;
    int                cycle_limit = 1000;

    id_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_with_failure("run went past its cycle limit without finishing");
        end
    end

    // ********************
    // compare tasks
    // ********************
    task automatic check_word(string name, id_pkg::word_t got, id_pkg::word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_ctrl(id_pkg::ctrl_t got, id_pkg::ctrl_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: id_to_ex.ctrl = %h, expected %h", got, exp));
        end
    endtask

    task automatic check_branch(id_pkg::branch_t got, id_pkg::branch_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: branch = %h, expected %h", got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    // ********************
    // encoders and expected values
    // ********************
    function automatic id_pkg::word_t r_inst(logic [5:0] fn, id_pkg::reg_addr_t rs,
                                             id_pkg::reg_addr_t rt, id_pkg::reg_addr_t rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic id_pkg::word_t i_inst(logic [5:0] op, id_pkg::reg_addr_t rs,
                                             id_pkg::reg_addr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic id_pkg::word_t j_inst(logic [5:0] op, logic [25:0] index);
        return {op, index};
    endfunction

    function automatic id_pkg::rf_write_t wr(logic we, id_pkg::reg_addr_t a, id_pkg::word_t d);
        return '{we: we, waddr: a, wdata: d};
    endfunction

    function automatic id_pkg::branch_t br_of(logic taken, id_pkg::word_t target);
        return '{taken: taken, target: target};
    endfunction

    function automatic id_pkg::ctrl_t mk_ctrl(int alu_bit, id_pkg::src1_sel_t s1,
                                              id_pkg::src2_sel_t s2, logic men, logic mwe,
                                              logic rwe, id_pkg::reg_addr_t wa, logic sel);
        id_pkg::ctrl_t c;
        c = '0;
        c.alu_op[alu_bit] = 1'b1;
        c.src1_sel   = s1;
        c.src2_sel   = s2;
        c.mem_en     = men;
        c.mem_we     = mwe;
        c.rf_we      = rwe;
        c.rf_waddr   = wa;
        c.sel_rf_res = sel;
        return c;
    endfunction

    function automatic id_pkg::ctrl_t r_ctrl(int alu_bit, id_pkg::reg_addr_t rd);
        return mk_ctrl(alu_bit, id_pkg::src1_rs, id_pkg::src2_rt, 1'b0, 1'b0, 1'b1, rd, 1'b0);
    endfunction

    function automatic id_pkg::ctrl_t i_ctrl(int alu_bit, id_pkg::src2_sel_t s2,
                                             id_pkg::reg_addr_t rt);
        return mk_ctrl(alu_bit, id_pkg::src1_rs, s2, 1'b0, 1'b0, 1'b1, rt, 1'b0);
    endfunction

    // ex first, then mem, then wb, then the register file
    function automatic id_pkg::word_t expect_operand(id_pkg::reg_addr_t a);
        if (ex_s.we && ex_s.waddr == a) return ex_s.wdata;
        if (mem_s.we && mem_s.waddr == a) return mem_s.wdata;
        if (wb_s.we && wb_s.waddr == a) return wb_s.wdata;
        return (a == 5'd0) ? 32'd0 : model[a];
    endfunction

    task automatic set_buses(id_pkg::rf_write_t ex, id_pkg::rf_write_t mem,
                             id_pkg::rf_write_t wb, logic ld);
        ex_s  = ex;
        mem_s = mem;
        wb_s  = wb;
        ld_s  = ld;
    endtask

    task automatic add(id_pkg::word_t inst, id_pkg::ctrl_t c, id_pkg::branch_t b);
        row_t              r;
        id_pkg::reg_addr_t rs;
        id_pkg::reg_addr_t rt;
        if (stl_s == 2'b11) begin
            // slot keeps the earlier instruction, outputs repeat
            r = rows[rows.size()-1];
        end else begin
            r.ex  = ex_s;
            r.mem = mem_s;
            r.wb  = wb_s;
            r.ld  = ld_s;
            // a bubble decodes as an all-zero word
            rs = (stl_s == 2'b10) ? 5'd0 : inst[25:21];
            rt = (stl_s == 2'b10) ? 5'd0 : inst[20:16];
            r.exp_pc    = (stl_s == 2'b10) ? 32'd0 : next_pc;
            r.exp_inst  = (stl_s == 2'b10) ? 32'd0 : inst;
            r.exp_rs    = expect_operand(rs);
            r.exp_rt    = expect_operand(rt);
            r.exp_ctrl  = (stl_s == 2'b10) ? '0 : c;
            r.exp_br    = (stl_s == 2'b10) ? '0 : b;
            r.exp_stall = ld_s && ex_s.we && (ex_s.waddr == rs || ex_s.waddr == rt);
        end
        r.pc   = next_pc;
        r.inst = inst;
        r.stl  = stl_s;
        // wb commits at the edge after the check
        if (r.wb.we && r.wb.waddr != 5'd0) begin
            model[r.wb.waddr] = r.wb.wdata;
        end
        rows.push_back(r);
        next_pc = next_pc + 32'd16;
        stl_s   = 2'b00;
    endtask

    // ********************
    // stimulus table
    // ********************
    task automatic build_table();
        set_buses('0, '0, '0, 1'b0);
        add(r_inst(id_pkg::fn_addu, 5'd1, 5'd2, 5'd9), r_ctrl(id_pkg::alu_add, 5'd9), '0);
        add(r_inst(id_pkg::fn_subu, 5'd3, 5'd4, 5'd10), r_ctrl(id_pkg::alu_sub, 5'd10), '0);
        add(r_inst(id_pkg::fn_and, 5'd5, 5'd6, 5'd11), r_ctrl(id_pkg::alu_and, 5'd11), '0);
        add(r_inst(id_pkg::fn_or, 5'd7, 5'd8, 5'd12), r_ctrl(id_pkg::alu_or, 5'd12), '0);
        add(r_inst(id_pkg::fn_xor, 5'd2, 5'd7, 5'd13), r_ctrl(id_pkg::alu_xor, 5'd13), '0);
        add(r_inst(id_pkg::fn_nor, 5'd1, 5'd0, 5'd14), r_ctrl(id_pkg::alu_nor, 5'd14), '0);
        add(r_inst(id_pkg::fn_slt, 5'd4, 5'd3, 5'd15), r_ctrl(id_pkg::alu_slt, 5'd15), '0);
        add(r_inst(id_pkg::fn_sltu, 5'd6, 5'd5, 5'd16), r_ctrl(id_pkg::alu_sltu, 5'd16), '0);
        add(i_inst(id_pkg::op_addiu, 5'd1, 5'd2, 16'hfff0),
            i_ctrl(id_pkg::alu_add, id_pkg::src2_imm_sext, 5'd2), '0);
        add(i_inst(id_pkg::op_andi, 5'd2, 5'd3, 16'h8001),
            i_ctrl(id_pkg::alu_and, id_pkg::src2_imm_zext, 5'd3), '0);
        add(i_inst(id_pkg::op_ori, 5'd3, 5'd4, 16'h00ff),
            i_ctrl(id_pkg::alu_or, id_pkg::src2_imm_zext, 5'd4), '0);
        add(i_inst(id_pkg::op_xori, 5'd4, 5'd6, 16'hf0f0),
            i_ctrl(id_pkg::alu_xor, id_pkg::src2_imm_zext, 5'd6), '0);
        add(i_inst(id_pkg::op_lui, 5'd0, 5'd7, 16'h1234),
            i_ctrl(id_pkg::alu_lui, id_pkg::src2_imm_sext, 5'd7), '0);
        add(i_inst(id_pkg::op_lw, 5'd1, 5'd5, 16'h0008), mk_ctrl(id_pkg::alu_add,
            id_pkg::src1_rs, id_pkg::src2_imm_sext, 1'b1, 1'b0, 1'b1, 5'd5, 1'b1), '0);
        add(i_inst(id_pkg::op_sw, 5'd2, 5'd6, 16'hfffc), mk_ctrl(id_pkg::alu_add,
            id_pkg::src1_rs, id_pkg::src2_imm_sext, 1'b1, 1'b1, 1'b0, 5'd0, 1'b0), '0);
        add(32'd0, '0, '0);

        // bypass priority on rs = r3, wb finally lands in the register file
        set_buses(wr(1'b1, 5'd3, 32'hee00_0001), wr(1'b1, 5'd3, 32'hdd00_0002),
                  wr(1'b1, 5'd3, 32'hcc00_0003), 1'b0);
        add(r_inst(id_pkg::fn_addu, 5'd3, 5'd4, 5'd22), r_ctrl(id_pkg::alu_add, 5'd22), '0);
        set_buses('0, wr(1'b1, 5'd3, 32'hdd00_0002), wr(1'b1, 5'd3, 32'hcc00_0003), 1'b0);
        add(r_inst(id_pkg::fn_addu, 5'd3, 5'd4, 5'd22), r_ctrl(id_pkg::alu_add, 5'd22), '0);
        set_buses('0, '0, wr(1'b1, 5'd3, 32'hcc00_0003), 1'b0);
        add(r_inst(id_pkg::fn_addu, 5'd3, 5'd4, 5'd22), r_ctrl(id_pkg::alu_add, 5'd22), '0);

        // load-use
        set_buses(wr(1'b1, 5'd4, 32'h1111_2222), '0, '0, 1'b1);
        add(r_inst(id_pkg::fn_addu, 5'd4, 5'd1, 5'd9), r_ctrl(id_pkg::alu_add, 5'd9), '0);
        set_buses(wr(1'b1, 5'd6, 32'h3333_4444), '0, '0, 1'b1);
        add(r_inst(id_pkg::fn_or, 5'd1, 5'd6, 5'd9), r_ctrl(id_pkg::alu_or, 5'd9), '0);
        set_buses(wr(1'b1, 5'd7, 32'h5555_6666), '0, '0, 1'b1);
        add(r_inst(id_pkg::fn_addu, 5'd1, 5'd2, 5'd9), r_ctrl(id_pkg::alu_add, 5'd9), '0);
        set_buses(wr(1'b1, 5'd1, 32'h7777_8888), '0, '0, 1'b0);
        add(r_inst(id_pkg::fn_addu, 5'd1, 5'd2, 5'd9), r_ctrl(id_pkg::alu_add, 5'd9), '0);
        set_buses(wr(1'b0, 5'd1, 32'h9999_aaaa), '0, '0, 1'b1);
        add(r_inst(id_pkg::fn_addu, 5'd1, 5'd2, 5'd9), r_ctrl(id_pkg::alu_add, 5'd9), '0);
        set_buses('0, '0, '0, 1'b0);

        // slot hold, then bubble
        add(i_inst(id_pkg::op_ori, 5'd2, 5'd3, 16'h00ff),
            i_ctrl(id_pkg::alu_or, id_pkg::src2_imm_zext, 5'd3), '0);
        stl_s = 2'b11;
        add(r_inst(id_pkg::fn_subu, 5'd5, 5'd6, 5'd7), '0, '0);
        stl_s = 2'b10;
        add(r_inst(id_pkg::fn_addu, 5'd1, 5'd2, 5'd3), '0, '0);

        // branches, pc stays well below a region boundary
        add(i_inst(id_pkg::op_beq, 5'd1, 5'd1, 16'h0003), '0, br_of(1'b1, next_pc + 32'd16));
        add(i_inst(id_pkg::op_beq, 5'd1, 5'd2, 16'hfffe), '0, br_of(1'b0, next_pc - 32'd4));
        add(i_inst(id_pkg::op_bne, 5'd1, 5'd2, 16'h0005), '0, br_of(1'b1, next_pc + 32'd24));
        add(i_inst(id_pkg::op_bne, 5'd3, 5'd3, 16'h0001), '0, br_of(1'b0, next_pc + 32'd8));
        add(j_inst(id_pkg::op_j, 26'h0043210), '0,
            br_of(1'b1, {next_pc[31:28], 26'h0043210, 2'b00}));
        add(j_inst(id_pkg::op_jal, 26'h0a50f0c), mk_ctrl(id_pkg::alu_add, id_pkg::src1_pc,
            id_pkg::src2_const8, 1'b0, 1'b0, 1'b1, 5'd31, 1'b0),
            br_of(1'b1, {next_pc[31:28], 26'h0a50f0c, 2'b00}));
        add(r_inst(id_pkg::fn_jr, 5'd3, 5'd0, 5'd0), '0, br_of(1'b1, model[3]));
    endtask

    initial begin
        row_t r;
        rst        = 1'b1;
        stall_if   = 1'b0;
        stall_id   = 1'b0;
        // live jal on the fetch side, only reset keeps it out of decode
        if_to_id   = '{valid: 1'b1, pc: 32'h0040_0000};
        inst_rdata = j_inst(id_pkg::op_jal, 26'h0000040);
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb_fwd     = '0;
        ex_is_load = 1'b0;
        seed       = 9;
        stl_s      = 2'b00;
        next_pc    = 32'h0040_0000;
        for (int i = 0; i < 32; i++) begin
            model[i] = (i == 0) ? 32'd0 : 'x;
        end
        for (int i = 1; i <= 8; i++) begin
            preload_val[i] = $random(seed);
            model[i]       = preload_val[i];
        end
        build_table();
        cycle_limit = 5 + 8 + 4 * rows.size() + 50;

        repeat (5) @(negedge clk);
        rst = 1'b0;

        // preload r1..r8 through writeback
        for (int i = 1; i <= 8; i++) begin
            @(negedge clk);
            wb_fwd = wr(1'b1, id_pkg::reg_addr_t'(i), preload_val[i]);
        end

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            @(negedge clk);
            if_to_id   = '{valid: 1'b1, pc: r.pc};
            stall_if   = r.stl[1];
            stall_id   = r.stl[0];
            ex_fwd     = '0;
            mem_fwd    = '0;
            wb_fwd     = '0;
            ex_is_load = 1'b0;
            @(negedge clk);
            inst_rdata = r.inst;
            ex_fwd     = r.ex;
            mem_fwd    = r.mem;
            wb_fwd     = r.wb;
            ex_is_load = r.ld;
            #10;
            check_word("id_to_ex.pc", id_to_ex.pc, r.exp_pc);
            check_word("id_to_ex.inst", id_to_ex.inst, r.exp_inst);
            check_word("id_to_ex.rs_val", id_to_ex.rs_val, r.exp_rs);
            check_word("id_to_ex.rt_val", id_to_ex.rt_val, r.exp_rt);
            check_ctrl(id_to_ex.ctrl, r.exp_ctrl);
            check_branch(branch, r.exp_br);
            check_bit("stall_for_load", stall_for_load, r.exp_stall);
        end

        $display("Test passed");
        $finish;
    end

endmodule
